/* list.f */
+incdir+source
source/cpu_pkg.sv
source/boot_loader.sv
source/inst_mem.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_top.sv
test/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_cpu -f list.f -o tb_cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
fi
exit $status

/* source/boot_loader.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"
`default_nettype none

module boot_loader (
	input wire clk,
	input wire reset,
	output logic flash_rd,
	output logic [`CPU_FLASH_AW-1:0] flash_addr,
	input wire cpu_pkg::word_t flash_data,
	input wire flash_ack,
	output logic imem_we,
	output logic [`CPU_IMEM_AW-1:0] imem_waddr,
	output cpu_pkg::word_t imem_wdata,
	output logic boot_done
);
	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_DONE} state_e;

	state_e state;
	logic last_word;

	assign last_word = (imem_waddr == `CPU_IMEM_AW'(`CPU_BOOT_WORDS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			flash_addr <= `CPU_BOOT_BASE;
			imem_waddr <= '0;
		end else begin
			case (state)
				ST_IDLE: state <= ST_READ;
				// Request stays up until the flash answers
				ST_READ: if (flash_ack) state <= ST_WRITE;
				ST_WRITE: begin
					flash_addr <= flash_addr + 1'b1;
					if (last_word) begin
						state <= ST_DONE;
					end else begin
						imem_waddr <= imem_waddr + 1'b1;
						state <= ST_READ;
					end
				end
				default: state <= ST_DONE;
			endcase
		end
	end

	// Flash word is only valid in the ack cycle
	always_ff @(posedge clk) begin
		if (state == ST_READ && flash_ack)
			imem_wdata <= flash_data;
	end

	assign flash_rd = (state == ST_READ);
	assign imem_we = (state == ST_WRITE);
	assign boot_done = (state == ST_DONE);

	// Idle once the whole image has been read
	a_done_quiet: assert property (@(posedge clk) disable iff (reset)
		boot_done |-> !flash_rd &&
		flash_addr == `CPU_FLASH_AW'(`CPU_BOOT_BASE + `CPU_BOOT_WORDS));

endmodule

`default_nettype wire

/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Program image copied from flash at boot
`define CPU_BOOT_WORDS 64

// Instruction memory holds the whole image
`define CPU_IMEM_AW 6

// Flash is word addressed
`define CPU_FLASH_AW 22

`define CPU_BOOT_BASE 22'h000100

`endif

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;

	typedef enum logic [4:0] {
		OP_NOP   = 5'b00001,
		OP_B     = 5'b00010,
		OP_BEQZ  = 5'b00100,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_RR    = 5'b11100
	} opcode_e;

	// Low two bits of a register-format word
	typedef enum logic [1:0] {
		FN_ADDU = 2'b00,
		FN_SUBU = 2'b01,
		FN_AND  = 2'b10,
		FN_OR   = 2'b11
	} funct_e;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR
	} alu_op_e;

	typedef struct packed {
		opcode_e   opcode;
		reg_addr_t rx;
		logic [7:0] imm8;
	} inst_i_t;

	typedef struct packed {
		opcode_e   opcode;
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t rz;
		funct_e    funct;
	} inst_r_t;

	typedef union packed {
		inst_i_t i;
		inst_r_t r;
	} inst_u;

	typedef struct packed {
		logic  valid;
		word_t pc;
		inst_u inst;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		word_t     op_a;
		word_t     op_b;
		logic      reg_write;
		reg_addr_t dest;
	} id_ex_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     value;
	} wb_write_t;

endpackage

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"
`default_nettype none

module cpu_top (
	input wire clk,
	input wire reset,
	output wire flash_rd,
	output wire [`CPU_FLASH_AW-1:0] flash_addr,
	input wire cpu_pkg::word_t flash_data,
	input wire flash_ack,
	output wire boot_done,
	output wire cpu_pkg::wb_write_t wb
);
	import cpu_pkg::*;

	wire imem_we;
	wire [`CPU_IMEM_AW-1:0] imem_waddr;
	wire word_t imem_wdata;
	wire [`CPU_IMEM_AW-1:0] imem_raddr;
	wire word_t imem_rdata;

	wire branch;
	wire word_t branch_target;
	wire if_id_t if_id;
	wire id_ex_t id_ex;
	wire wb_write_t ex_fwd;

	wire reg_addr_t rd_addr_a;
	wire reg_addr_t rd_addr_b;
	wire word_t rd_data_a;
	wire word_t rd_data_b;

	boot_loader u_boot_loader (
		.clk(clk),
		.reset(reset),
		.flash_rd(flash_rd),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ack(flash_ack),
		.imem_we(imem_we),
		.imem_waddr(imem_waddr),
		.imem_wdata(imem_wdata),
		.boot_done(boot_done)
	);

	inst_mem u_inst_mem (
		.clk(clk),
		.we(imem_we),
		.waddr(imem_waddr),
		.wdata(imem_wdata),
		.raddr(imem_raddr),
		.rdata(imem_rdata)
	);

	fetch_stage u_fetch_stage (
		.clk(clk),
		.reset(reset),
		.boot_done(boot_done),
		.branch(branch),
		.branch_target(branch_target),
		.imem_raddr(imem_raddr),
		.imem_rdata(imem_rdata),
		.if_id(if_id)
	);

	decode_stage u_decode_stage (
		.clk(clk),
		.reset(reset),
		.if_id(if_id),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.ex_fwd(ex_fwd),
		.branch(branch),
		.branch_target(branch_target),
		.id_ex(id_ex)
	);

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wb(wb)
	);

	execute_stage u_execute_stage (
		.clk(clk),
		.reset(reset),
		.id_ex(id_ex),
		.ex_fwd(ex_fwd),
		.wb(wb)
	);

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::if_id_t if_id,
	output cpu_pkg::reg_addr_t rd_addr_a,
	output cpu_pkg::reg_addr_t rd_addr_b,
	input wire cpu_pkg::word_t rd_data_a,
	input wire cpu_pkg::word_t rd_data_b,
	input wire cpu_pkg::wb_write_t ex_fwd,
	output logic branch,
	output cpu_pkg::word_t branch_target,
	output cpu_pkg::id_ex_t id_ex
);
	import cpu_pkg::*;

	word_t opnd_a;
	word_t opnd_b;
	word_t imm_sext;
	word_t imm_zext;
	id_ex_t id_ex_next;

	assign rd_addr_a = if_id.inst.i.rx;
	assign rd_addr_b = if_id.inst.r.ry;

	// Result still in execute wins over the register file
	assign opnd_a = (ex_fwd.en && ex_fwd.addr == rd_addr_a) ? ex_fwd.value : rd_data_a;
	assign opnd_b = (ex_fwd.en && ex_fwd.addr == rd_addr_b) ? ex_fwd.value : rd_data_b;

	assign imm_sext = {{8{if_id.inst.i.imm8[7]}}, if_id.inst.i.imm8};
	assign imm_zext = {8'h00, if_id.inst.i.imm8};
	assign branch_target = if_id.pc + 16'd1 + imm_sext;

	always_comb begin
		id_ex_next = '0;
		id_ex_next.valid = if_id.valid;
		id_ex_next.alu_op = ALU_PASS_B;
		id_ex_next.op_a = opnd_a;
		id_ex_next.op_b = opnd_b;
		id_ex_next.dest = if_id.inst.i.rx;
		branch = 1'b0;
		case (if_id.inst.i.opcode)
			OP_LI: begin
				id_ex_next.op_b = imm_zext;
				id_ex_next.reg_write = 1'b1;
			end
			OP_ADDIU: begin
				id_ex_next.alu_op = ALU_ADD;
				id_ex_next.op_b = imm_sext;
				id_ex_next.reg_write = 1'b1;
			end
			OP_RR: begin
				id_ex_next.dest = if_id.inst.r.rz;
				id_ex_next.reg_write = 1'b1;
				case (if_id.inst.r.funct)
					FN_ADDU: id_ex_next.alu_op = ALU_ADD;
					FN_SUBU: id_ex_next.alu_op = ALU_SUB;
					FN_AND: id_ex_next.alu_op = ALU_AND;
					default: id_ex_next.alu_op = ALU_OR;
				endcase
			end
			OP_BEQZ: branch = if_id.valid && (opnd_a == '0);
			OP_B: branch = if_id.valid;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.valid <= 1'b0;
			id_ex.reg_write <= 1'b0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

	// Delay slot is the next sequential word
	a_branch_slot: assert property (@(posedge clk) disable iff (reset)
		branch |=> if_id.valid && if_id.pc == $past(if_id.pc) + 16'd1);

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::id_ex_t id_ex,
	output cpu_pkg::wb_write_t ex_fwd,
	output cpu_pkg::wb_write_t wb
);
	import cpu_pkg::*;

	word_t alu_result;

	always_comb begin
		case (id_ex.alu_op)
			ALU_ADD: alu_result = id_ex.op_a + id_ex.op_b;
			ALU_SUB: alu_result = id_ex.op_a - id_ex.op_b;
			ALU_AND: alu_result = id_ex.op_a & id_ex.op_b;
			ALU_OR: alu_result = id_ex.op_a | id_ex.op_b;
			default: alu_result = id_ex.op_b;
		endcase
	end

	// Offered back to decode for forwarding
	always_comb begin
		ex_fwd.en = id_ex.valid && id_ex.reg_write;
		ex_fwd.addr = id_ex.dest;
		ex_fwd.value = alu_result;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.en <= 1'b0;
		end else begin
			wb <= ex_fwd;
		end
	end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"
`default_nettype none

module fetch_stage (
	input wire clk,
	input wire reset,
	input wire boot_done,
	input wire branch,
	input wire cpu_pkg::word_t branch_target,
	output logic [`CPU_IMEM_AW-1:0] imem_raddr,
	input wire cpu_pkg::word_t imem_rdata,
	output cpu_pkg::if_id_t if_id
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_next;
	word_t fetch_pc;
	logic fetch_valid;

	always_comb begin
		if (!boot_done)
			pc_next = '0;
		else if (branch)
			pc_next = branch_target;
		else
			pc_next = pc + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else begin
			pc <= pc_next;
			fetch_valid <= boot_done;
		end
	end

	// Pc follows its word through the memory read
	always_ff @(posedge clk) begin
		fetch_pc <= pc;
	end

	assign imem_raddr = pc[`CPU_IMEM_AW-1:0];

	always_comb begin
		if_id.valid = fetch_valid;
		if_id.pc = fetch_pc;
		if_id.inst = imem_rdata;
	end

	a_pc_boot_hold: assert property (@(posedge clk) disable iff (reset)
		!boot_done |=> $stable(pc));

endmodule

`default_nettype wire

/* source/inst_mem.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"
`default_nettype none

module inst_mem (
	input wire clk,
	input wire we,
	input wire [`CPU_IMEM_AW-1:0] waddr,
	input wire cpu_pkg::word_t wdata,
	input wire [`CPU_IMEM_AW-1:0] raddr,
	output cpu_pkg::word_t rdata
);
	import cpu_pkg::*;

	word_t mem [2**`CPU_IMEM_AW];

	// Registered read so this maps onto block RAM
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::reg_addr_t rd_addr_a,
	input wire cpu_pkg::reg_addr_t rd_addr_b,
	output cpu_pkg::word_t rd_data_a,
	output cpu_pkg::word_t rd_data_b,
	input wire cpu_pkg::wb_write_t wb
);
	import cpu_pkg::*;

	word_t regs [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wb.en) begin
			regs[wb.addr] <= wb.value;
		end
	end

	// Write-through covers the write-back stage
	assign rd_data_a = (wb.en && wb.addr == rd_addr_a) ? wb.value : regs[rd_addr_a];
	assign rd_data_b = (wb.en && wb.addr == rd_addr_b) ? wb.value : regs[rd_addr_b];

endmodule

`default_nettype wire

/* test/tb_cpu.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic flash_rd;
	logic [`CPU_FLASH_AW-1:0] flash_addr;
	word_t flash_data = '0;
	logic flash_ack = 1'b0;
	logic boot_done;
	wb_write_t wb;

	integer seed = 32'ha255_4f57;
	word_t image [`CPU_BOOT_WORDS];
	wb_write_t expected_q [$];
	int ref_count;
	int wb_count = 0;
	int ack_count = 0;
	int flash_wait = 0;
	logic flash_busy = 1'b0;
	logic [`CPU_FLASH_AW-1:0] req_addr;

	cpu_top dut0 (
		.clk(clk),
		.reset(reset),
		.flash_rd(flash_rd),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ack(flash_ack),
		.boot_done(boot_done),
		.wb(wb)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
			abort_run("value check failed");
		end
	endtask

	function automatic word_t encode_imm(opcode_e op, reg_addr_t rx, logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic word_t encode_reg(reg_addr_t rx, reg_addr_t ry, reg_addr_t rz,
			funct_e fn);
		return {OP_RR, rx, ry, rz, fn};
	endfunction

	function automatic int random_delay();
		return int'({$random(seed)} % 32'd6);
	endfunction

	function automatic void build_image();
		logic [7:0] a8;

		// Words past the final loop are never fetched
		for (int a = 0; a < `CPU_BOOT_WORDS; a++) begin
			a8 = 8'(a);
			image[a[`CPU_IMEM_AW-1:0]] = encode_imm(OP_LI, a8[2:0], a8 ^ 8'ha5);
		end
		image[0] = encode_imm(OP_LI, 3'd1, 8'h05);
		image[1] = encode_imm(OP_LI, 3'd2, 8'h80);
		image[2] = encode_imm(OP_ADDIU, 3'd1, 8'hff);
		image[3] = encode_reg(3'd1, 3'd2, 3'd3, FN_ADDU);
		image[4] = encode_reg(3'd3, 3'd1, 3'd4, FN_SUBU);
		image[5] = encode_reg(3'd4, 3'd2, 3'd5, FN_AND);
		image[6] = encode_reg(3'd5, 3'd1, 3'd6, FN_OR);
		// r0 is 3 in write-back and 0 in execute when the BEQZ decodes
		image[7] = encode_imm(OP_LI, 3'd0, 8'h03);
		image[8] = encode_imm(OP_ADDIU, 3'd0, 8'hfd);
		image[9] = encode_imm(OP_BEQZ, 3'd0, 8'h03);
		image[10] = encode_imm(OP_ADDIU, 3'd1, 8'h02);
		image[11] = encode_imm(OP_LI, 3'd2, 8'hee);
		image[12] = encode_imm(OP_LI, 3'd3, 8'hee);
		image[13] = encode_imm(OP_BEQZ, 3'd1, 8'h04);
		image[14] = encode_imm(OP_ADDIU, 3'd2, 8'h01);
		image[15] = encode_imm(OP_B, 3'd0, 8'h02);
		image[16] = encode_reg(3'd2, 3'd6, 3'd5, FN_SUBU);
		image[17] = encode_imm(OP_LI, 3'd6, 8'hee);
		image[18] = encode_reg(3'd5, 3'd6, 3'd7, FN_OR);
		image[19] = encode_imm(OP_ADDIU, 3'd3, 8'h80);
		image[20] = encode_imm(OP_B, 3'd0, 8'hff);
		image[21] = encode_imm(OP_NOP, 3'd0, 8'h00);
	endfunction

	// Instruction-set model that returns the write count up to the branch-to-self loop
	function automatic int run_reference();
		word_t regs [8];
		word_t pc;
		word_t next_pc;
		word_t word;
		word_t sext;
		word_t slot_target;
		logic slot_pending;
		logic stop_after_slot;
		logic taken;
		logic wr_en;
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t wr_addr;
		word_t wr_val;
		wb_write_t w;

		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		pc = '0;
		slot_target = '0;
		slot_pending = 1'b0;
		stop_after_slot = 1'b0;
		expected_q.delete();
		for (int step = 0; step < 1000; step++) begin
			word = image[pc[`CPU_IMEM_AW-1:0]];
			rx = word[10:8];
			ry = word[7:5];
			sext = {{8{word[7]}}, word[7:0]};
			wr_en = 1'b0;
			wr_addr = rx;
			wr_val = '0;
			taken = 1'b0;
			case (word[15:11])
				OP_LI: begin
					wr_en = 1'b1;
					wr_val = {8'h00, word[7:0]};
				end
				OP_ADDIU: begin
					wr_en = 1'b1;
					wr_val = regs[rx] + sext;
				end
				OP_RR: begin
					wr_en = 1'b1;
					wr_addr = word[4:2];
					case (word[1:0])
						FN_ADDU: wr_val = regs[rx] + regs[ry];
						FN_SUBU: wr_val = regs[rx] - regs[ry];
						FN_AND: wr_val = regs[rx] & regs[ry];
						default: wr_val = regs[rx] | regs[ry];
					endcase
				end
				OP_BEQZ: taken = (regs[rx] == 16'd0);
				OP_B: taken = 1'b1;
				default: ;
			endcase
			if (wr_en) begin
				regs[wr_addr] = wr_val;
				w.en = 1'b1;
				w.addr = wr_addr;
				w.value = wr_val;
				expected_q.push_back(w);
			end
			// Delay slot runs before the earlier branch redirects
			if (slot_pending) begin
				if (stop_after_slot)
					return expected_q.size();
				next_pc = slot_target;
				slot_pending = 1'b0;
			end else begin
				next_pc = pc + 16'd1;
			end
			if (taken) begin
				slot_target = pc + 16'd1 + sext;
				slot_pending = 1'b1;
				stop_after_slot = (slot_target == pc);
			end
			pc = next_pc;
		end
		return -1;
	endfunction

	// Flash with a random acknowledge delay per request
	always @(posedge clk) begin
		if (reset) begin
			flash_ack <= 1'b0;
			flash_busy <= 1'b0;
			flash_wait <= 0;
			ack_count <= 0;
		end else begin
			flash_ack <= 1'b0;
			if (flash_busy) begin
				if (flash_rd !== 1'b1) begin
					abort_run("flash request dropped before its acknowledge");
				end else begin
					check_value("flash address while waiting", 32'(flash_addr), 32'(req_addr));
					if (flash_wait == 0) begin
						flash_ack <= 1'b1;
						flash_data <= image[ack_count[`CPU_IMEM_AW-1:0]];
						ack_count <= ack_count + 1;
						flash_busy <= 1'b0;
					end else begin
						flash_wait <= flash_wait - 1;
					end
				end
			end else if (flash_rd === 1'b1 && !flash_ack) begin
				if (ack_count >= `CPU_BOOT_WORDS) begin
					abort_run("flash read requested after the whole image was sent");
				end else begin
					check_value("flash address", 32'(flash_addr),
						32'(`CPU_BOOT_BASE) + 32'(ack_count));
					req_addr <= flash_addr;
					flash_wait <= random_delay();
					flash_busy <= 1'b1;
				end
			end
		end
	end

	// Write-back compare
	always @(posedge clk) begin
		if (!reset && wb.en === 1'b1) begin
			if (wb_count >= expected_q.size()) begin
				abort_run($sformatf("unexpected write to r%0d after the final loop", wb.addr));
			end else begin
				check_value("boot_done during write", 32'(boot_done), 32'd1);
				check_value("write address", 32'(wb.addr), 32'(expected_q[wb_count].addr));
				check_value("write value", 32'(wb.value), 32'(expected_q[wb_count].value));
				wb_count <= wb_count + 1;
			end
		end
	end

	initial begin
		int cycles;

		build_image();
		ref_count = run_reference();
		if (ref_count <= 0) begin
			abort_run("reference program never reaches its final loop");
		end else begin
			repeat (10) @(posedge clk);
			check_value("flash_rd in reset", 32'(flash_rd), 32'd0);
			check_value("boot_done in reset", 32'(boot_done), 32'd0);
			check_value("wb.en in reset", 32'(wb.en), 32'd0);
			reset <= 1'b0;

			cycles = 0;
			while (boot_done !== 1'b1) begin
				@(posedge clk);
				cycles++;
				if (cycles > 2000)
					abort_run("boot_done did not rise within 2000 cycles");
			end
			check_value("acknowledges at boot_done", 32'(ack_count), 32'(`CPU_BOOT_WORDS));

			cycles = 0;
			while (wb_count < ref_count) begin
				@(posedge clk);
				cycles++;
				if (cycles > 500)
					abort_run("register writes stopped before the expected count");
			end

			// Final loop must stay silent
			repeat (50) @(posedge clk);
			if (wb_count == ref_count) begin
				$display("*** PASSED ***");
				$finish;
			end else begin
				abort_run("extra register writes after the final loop");
			end
		end
	end

endmodule

`default_nettype wire
